/* bench/store_unit_tb.sv */
`timescale 1ns/10ps

`include "store_unit_settings.svh"

module store_unit_tb;

    localparam logic [6:0] STORE_OPCODE = 7'b0100011;
    // All tests together run a few hundred cycles
    localparam int MAX_CYCLES = 3000;

    logic                    clk;
    logic                    reset;
    logic                    iss_valid;
    logic [6:0]              iss_opcode;
    logic [2:0]              iss_funct3;
    store_unit_pkg::t_rob_id iss_robid;
    store_unit_pkg::t_stq_id iss_stqid;
    logic [`ADDR_BITS-1:0]   iss_src1;
    logic [`ADDR_BITS-1:0]   iss_imm;
    logic [`DATA_BITS-1:0]   iss_src2;
    logic                    nuke_valid;
    store_unit_pkg::t_rob_id nuke_robid;
    store_unit_pkg::t_rob_id oldest_robid;
    logic                    port_blocked;
    logic                    idle;
    logic                    mem_wr_valid;
    logic [`ADDR_BITS-1:0]   mem_wr_addr;
    logic [`DATA_BITS-1:0]   mem_wr_data;
    logic [`DATA_BITS/8-1:0] mem_wr_be;

    int          cycle_count = 0;
    int          fail_count = 0;
    logic [31:0] rand_state = 32'h5507;

    // Writes seen on the memory port, oldest first
    logic [`ADDR_BITS-1:0]   wr_addr_q [$];
    logic [`DATA_BITS-1:0]   wr_data_q [$];
    logic [`DATA_BITS/8-1:0] wr_be_q [$];
    int                      wr_cycle_q [$];

    store_unit_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // Write monitor samples mid-cycle where outputs are stable
    always @(negedge clk) begin
        if (!reset && mem_wr_valid) begin
            wr_addr_q.push_back(mem_wr_addr);
            wr_data_q.push_back(mem_wr_data);
            wr_be_q.push_back(mem_wr_be);
            wr_cycle_q.push_back(cycle_count);
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic report_mismatch(input string msg);
        fail_count++;
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string msg);
        fail_count++;
        $display("Error at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic issue_store(input store_unit_pkg::t_rob_id robid,
                               input store_unit_pkg::t_stq_id stqid, input logic [2:0] funct3,
                               input logic [31:0] src1, input logic [31:0] imm,
                               input logic [63:0] src2);
        iss_valid  = 1'b1;
        iss_opcode = STORE_OPCODE;
        iss_funct3 = funct3;
        iss_robid  = robid;
        iss_stqid  = stqid;
        iss_src1   = src1;
        iss_imm    = imm;
        iss_src2   = src2;
        @(negedge clk);
        iss_valid = 1'b0;
    endtask

    task automatic pulse_nuke(input store_unit_pkg::t_rob_id robid);
        nuke_valid = 1'b1;
        nuke_robid = robid;
        @(negedge clk);
        nuke_valid = 1'b0;
    endtask

    task automatic wait_for_writes(input int count);
        while (wr_addr_q.size() < count) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic expect_no_writes(input int cycles);
        repeat (cycles) @(posedge clk);
        assert (wr_addr_q.size() == 0)
            else report_problem("a memory write appeared that no store should make");
        @(negedge clk);
    endtask

    task automatic check_next_write(input logic [31:0] addr, input logic [63:0] data,
                                    input logic [7:0] be);
        logic [31:0] got_addr;
        logic [63:0] got_data;
        logic [7:0]  got_be;
        got_addr = wr_addr_q.pop_front();
        got_data = wr_data_q.pop_front();
        got_be   = wr_be_q.pop_front();
        void'(wr_cycle_q.pop_front());
        assert (got_addr === addr)
            else report_mismatch($sformatf("addr %h, expected %h", got_addr, addr));
        assert (got_data === data)
            else report_mismatch($sformatf("data %h, expected %h", got_data, data));
        assert (got_be === be)
            else report_mismatch($sformatf("be %h, expected %h", got_be, be));
    endtask

    task automatic single_store_test();
        logic [31:0] src1;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [63:0] src2;
        int          issue_cycle;
        src1 = next_rand();
        imm  = 32'h40 - (src1 & 32'h7);
        src2 = {next_rand(), next_rand()};
        addr = src1 + imm;
        oldest_robid = 5'd1;
        issue_cycle  = cycle_count;
        issue_store(5'd1, 3'd2, 3'd3, src1, imm, src2);
        wait_for_writes(1);
        // First eligible cycle is the one after the allocating edge
        assert (wr_cycle_q[0] == issue_cycle + 7) else report_mismatch("single store latency");
        check_next_write({addr[31:3], 3'b000}, src2, 8'hff);
        assert (idle) else report_mismatch("idle low after single store");
        expect_no_writes(10);
    endtask

    task automatic size_align_test();
        logic [31:0]             addr;
        logic [31:0]             imm;
        logic [63:0]             src2;
        logic [2:0]              lane;
        int                      nbytes;
        int                      be_mask;
        store_unit_pkg::t_rob_id robid;
        robid = 5'd2;
        for (int f = 0; f < 3; f++) begin
            nbytes = 1 << f;
            for (int k = 0; k < 4; k++) begin
                addr    = next_rand() & ~(nbytes - 1);
                imm     = next_rand() & 32'h7ff;
                src2    = {next_rand(), next_rand()};
                lane    = addr[2:0];
                be_mask = ((1 << nbytes) - 1) << lane;
                oldest_robid = robid;
                issue_store(robid, robid[2:0], f[2:0], addr - imm, imm, src2);
                wait_for_writes(1);
                check_next_write({addr[31:3], 3'b000}, src2 << (8 * lane), be_mask[7:0]);
                robid = robid + 5'd1;
            end
        end
        expect_no_writes(10);
    endtask

    task automatic program_order_test();
        int          order [5];
        int          slots [5];
        logic [31:0] addrs [5];
        logic [63:0] datas [5];
        int          k;
        order = '{3, 1, 4, 0, 2};
        slots = '{5, 1, 7, 0, 3};
        oldest_robid = 5'd29;
        // Store k has robid 30+k and the robids run across the ROB wrap
        for (int i = 0; i < 5; i++) begin
            k = order[i];
            addrs[k] = next_rand() & ~32'h7;
            datas[k] = {next_rand(), next_rand()};
            issue_store(store_unit_pkg::t_rob_id'(30 + k), slots[k][2:0], 3'd3,
                        addrs[k] - 32'd8 * k, 32'd8 * k, datas[k]);
        end
        expect_no_writes(10);
        assert (!idle) else report_mismatch("idle high with stores queued");
        for (int j = 0; j < 5; j++) begin
            oldest_robid = store_unit_pkg::t_rob_id'(30 + j);
            wait_for_writes(1);
            check_next_write(addrs[j], datas[j], 8'hff);
        end
        expect_no_writes(10);
        assert (idle) else report_mismatch("idle low after ordered stores");
    endtask

    task automatic port_blocked_test();
        logic [63:0] data;
        int          start_cycle;
        data = {next_rand(), next_rand()};
        port_blocked = 1'b1;
        oldest_robid = 5'd3;
        issue_store(5'd3, 3'd6, 3'd3, 32'h1000, 32'h20, data);
        expect_no_writes(15);
        start_cycle  = cycle_count;
        port_blocked = 1'b0;
        wait_for_writes(1);
        assert (wr_cycle_q[0] == start_cycle + 6) else report_mismatch("write after unblock");
        check_next_write(32'h1020, data, 8'hff);
        // Second store loses the write port right at mm5
        data = {next_rand(), next_rand()};
        oldest_robid = 5'd4;
        start_cycle  = cycle_count;
        issue_store(5'd4, 3'd3, 3'd3, 32'h2000, 32'h8, data);
        while (cycle_count < start_cycle + 6) @(negedge clk);
        port_blocked = 1'b1;
        @(negedge clk);
        port_blocked = 1'b0;
        wait_for_writes(1);
        assert (wr_cycle_q[0] == start_cycle + 13) else report_mismatch("replayed write timing");
        check_next_write(32'h2008, data, 8'hff);
        expect_no_writes(15);
        assert (idle) else report_mismatch("idle low after replay");
    endtask

    task automatic nuke_test();
        logic [63:0] datas [4];
        int          slots [4];
        slots = '{4, 6, 2, 5};
        oldest_robid = 5'd29;
        for (int k = 0; k < 4; k++) begin
            datas[k] = {next_rand(), next_rand()};
            issue_store(store_unit_pkg::t_rob_id'(30 + k), slots[k][2:0], 3'd3,
                        32'h3000 + 32'd8 * k, 32'd0, datas[k]);
        end
        // Robids 0 and 1 sit past the wrap and go while 30 and 31 stay
        pulse_nuke(5'd0);
        for (int k = 0; k < 2; k++) begin
            oldest_robid = store_unit_pkg::t_rob_id'(30 + k);
            wait_for_writes(1);
            check_next_write(32'h3000 + 32'd8 * k, datas[k], 8'hff);
        end
        assert (idle) else report_mismatch("idle low after nuke and older writes");
        oldest_robid = 5'd0;
        expect_no_writes(12);
        oldest_robid = 5'd1;
        expect_no_writes(12);
        // Covered store already in the pipe at mm2
        oldest_robid = 5'd2;
        issue_store(5'd2, 3'd0, 3'd3, 32'h4000, 32'd0, {next_rand(), next_rand()});
        issue_store(5'd3, 3'd1, 3'd3, 32'h4008, 32'd0, {next_rand(), next_rand()});
        @(negedge clk);
        pulse_nuke(5'd2);
        expect_no_writes(15);
        assert (idle) else report_mismatch("idle low after in-flight nuke");
    endtask

    initial begin
        reset        = 1'b1;
        iss_valid    = 1'b0;
        iss_opcode   = '0;
        iss_funct3   = '0;
        iss_robid    = '0;
        iss_stqid    = '0;
        iss_src1     = '0;
        iss_imm      = '0;
        iss_src2     = '0;
        nuke_valid   = 1'b0;
        nuke_robid   = '0;
        oldest_robid = '0;
        port_blocked = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (idle && !mem_wr_valid) else report_mismatch("state after reset");
        single_store_test();
        size_align_test();
        program_order_test();
        port_blocked_test();
        nuke_test();
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+logic
logic/store_unit_pkg.sv
logic/store_issue_decode.sv
logic/store_queue_entry.sv
logic/find_first_arbiter.sv
logic/store_queue.sv
logic/store_mem_pipe.sv
logic/store_write_format.sv
logic/store_unit_top.sv
bench/store_unit_tb.sv

/* logic/find_first_arbiter.sv */
`timescale 1ns/10ps

module find_first_arbiter #(
    parameter int  NREQS = 4,
    parameter type T     = logic
) (
    input  logic [NREQS-1:0] req_valids,
    input  T                 req_pkts [NREQS-1:0],
    output logic [NREQS-1:0] gnts,
    output logic             ext_req_valid,
    output T                 ext_req_pkt,
    input  logic             ext_gnt
);

    logic [NREQS-1:0] sel;
    logic             found;

    // Lowest index wins
    always_comb begin
        sel         = '0;
        found       = 1'b0;
        ext_req_pkt = req_pkts[0];
        for (int i = 0; i < NREQS; i++) begin
            if (req_valids[i] && !found) begin
                sel[i]      = 1'b1;
                found       = 1'b1;
                ext_req_pkt = req_pkts[i];
            end
        end
    end

    assign ext_req_valid = found;
    assign gnts          = ext_gnt ? sel : '0;

endmodule

/* logic/store_issue_decode.sv */
`timescale 1ns/10ps

`include "store_unit_settings.svh"

module store_issue_decode (
    input  logic                         iss_valid,
    input  logic [6:0]                   iss_opcode,
    input  logic [2:0]                   iss_funct3,
    input  store_unit_pkg::t_rob_id      iss_robid,
    input  store_unit_pkg::t_stq_id      iss_stqid,
    input  logic [`ADDR_BITS-1:0]        iss_src1,
    input  logic [`ADDR_BITS-1:0]        iss_imm,
    input  logic [`DATA_BITS-1:0]        iss_src2,
    output logic                         alloc_valid,
    output store_unit_pkg::t_stq_id      alloc_stqid,
    output store_unit_pkg::t_mempipe_req alloc_req
);

    // RISC-V STORE major opcode
    localparam logic [6:0] STORE_OPCODE = 7'b0100011;

    logic is_store;

    // funct3 of 0..3 selects SB/SH/SW/SD
    assign is_store    = (iss_opcode == STORE_OPCODE) && !iss_funct3[2];
    assign alloc_valid = iss_valid && is_store;
    assign alloc_stqid = iss_stqid;

    always_comb begin
        alloc_req.robid = iss_robid;
        alloc_req.stqid = iss_stqid;
        alloc_req.addr  = iss_src1 + iss_imm;
        alloc_req.data  = iss_src2;
        alloc_req.size  = store_unit_pkg::t_op_size'(iss_funct3[1:0]);
    end

endmodule

/* logic/store_mem_pipe.sv */
`timescale 1ns/10ps

`include "store_unit_settings.svh"

module store_mem_pipe (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            pipe_req,
    input  store_unit_pkg::t_mempipe_req    pipe_req_pkt,
    input  logic                            port_blocked,
    input  logic                            nuke_valid,
    input  store_unit_pkg::t_rob_id         nuke_robid,
    output logic                            pipe_gnt,
    output logic                            pipe_valid_mm5,
    output store_unit_pkg::t_mempipe_req    pipe_pkt_mm5,
    output store_unit_pkg::t_mempipe_action pipe_action_mm5
);

    // Index 0 is mm1 and the last index is mm5
    logic [`PIPE_STAGES-1:0]      stg_valid;
    store_unit_pkg::t_mempipe_req stg_pkt [`PIPE_STAGES-1:0];

    logic [`PIPE_STAGES-1:0] stg_in_valid;
    store_unit_pkg::t_mempipe_req stg_in_pkt [`PIPE_STAGES-1:0];

    // No new store enters while a fill owns the write port
    assign pipe_gnt = !port_blocked;

    always_comb begin
        stg_in_valid[0] = pipe_req && pipe_gnt;
        stg_in_pkt[0]   = pipe_req_pkt;
        for (int s = 1; s < `PIPE_STAGES; s++) begin
            stg_in_valid[s] = stg_valid[s-1];
            stg_in_pkt[s]   = stg_pkt[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stg_valid <= '0;
        end else begin
            for (int s = 0; s < `PIPE_STAGES; s++) begin
                // Squash anything the nuke covers
                stg_valid[s] <= stg_in_valid[s] && !(nuke_valid &&
                    store_unit_pkg::rob_older_or_equal(nuke_robid, stg_in_pkt[s].robid));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `PIPE_STAGES; s++) begin
            stg_pkt[s] <= stg_in_pkt[s];
        end
    end

    assign pipe_valid_mm5  = stg_valid[`PIPE_STAGES-1];
    assign pipe_pkt_mm5    = stg_pkt[`PIPE_STAGES-1];

    // Write port lost to a fill at mm5 sends the store back for replay
    assign pipe_action_mm5 = port_blocked ? store_unit_pkg::ACTION_REPLAY
                                          : store_unit_pkg::ACTION_COMPLETE;

endmodule

/* logic/store_queue.sv */
`timescale 1ns/10ps

`include "store_unit_settings.svh"

module store_queue (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            alloc_valid,
    input  store_unit_pkg::t_stq_id         alloc_stqid,
    input  store_unit_pkg::t_mempipe_req    alloc_req,
    input  store_unit_pkg::t_rob_id         oldest_robid,
    input  logic                            nuke_valid,
    input  store_unit_pkg::t_rob_id         nuke_robid,
    input  logic                            pipe_gnt,
    input  logic                            pipe_valid_mm5,
    input  store_unit_pkg::t_mempipe_req    pipe_pkt_mm5,
    input  store_unit_pkg::t_mempipe_action pipe_action_mm5,
    output logic                            pipe_req,
    output store_unit_pkg::t_mempipe_req    pipe_req_pkt,
    output logic                            idle
);

    logic [`STQ_NUM_ENTRIES-1:0] e_alloc;
    logic [`STQ_NUM_ENTRIES-1:0] e_valid;
    logic [`STQ_NUM_ENTRIES-1:0] e_pipe_req;
    logic [`STQ_NUM_ENTRIES-1:0] e_pipe_gnt;

    store_unit_pkg::t_mempipe_req e_pipe_req_pkt [`STQ_NUM_ENTRIES-1:0];

    always_comb begin
        e_alloc              = '0;
        e_alloc[alloc_stqid] = alloc_valid;
    end

    find_first_arbiter #(
        .NREQS (`STQ_NUM_ENTRIES),
        .T     (store_unit_pkg::t_mempipe_req)
    ) i_pipe_arb (
        .req_valids    (e_pipe_req),
        .req_pkts      (e_pipe_req_pkt),
        .gnts          (e_pipe_gnt),
        .ext_req_valid (pipe_req),
        .ext_req_pkt   (pipe_req_pkt),
        .ext_gnt       (pipe_gnt)
    );

    for (genvar e = 0; e < `STQ_NUM_ENTRIES; e++) begin : g_entries
        store_queue_entry i_entry (
            .clk             (clk),
            .reset           (reset),
            .id              (store_unit_pkg::t_stq_id'(e)),
            .alloc           (e_alloc[e]),
            .alloc_req       (alloc_req),
            .oldest_robid    (oldest_robid),
            .nuke_valid      (nuke_valid),
            .nuke_robid      (nuke_robid),
            .pipe_gnt        (e_pipe_gnt[e]),
            .pipe_valid_mm5  (pipe_valid_mm5),
            .pipe_pkt_mm5    (pipe_pkt_mm5),
            .pipe_action_mm5 (pipe_action_mm5),
            .valid           (e_valid[e]),
            .pipe_req        (e_pipe_req[e]),
            .pipe_req_pkt    (e_pipe_req_pkt[e])
        );
    end

    assign idle = ~|e_valid;

endmodule

/* logic/store_queue_entry.sv */
`timescale 1ns/10ps

module store_queue_entry (
    input  logic                            clk,
    input  logic                            reset,
    input  store_unit_pkg::t_stq_id         id,
    input  logic                            alloc,
    input  store_unit_pkg::t_mempipe_req    alloc_req,
    input  store_unit_pkg::t_rob_id         oldest_robid,
    input  logic                            nuke_valid,
    input  store_unit_pkg::t_rob_id         nuke_robid,
    input  logic                            pipe_gnt,
    input  logic                            pipe_valid_mm5,
    input  store_unit_pkg::t_mempipe_req    pipe_pkt_mm5,
    input  store_unit_pkg::t_mempipe_action pipe_action_mm5,
    output logic                            valid,
    output logic                            pipe_req,
    output store_unit_pkg::t_mempipe_req    pipe_req_pkt
);

    store_unit_pkg::t_mempipe_req req;

    logic in_pipe;
    logic nuke_hit;
    logic alloc_ok;
    logic mm5_hit;
    logic mm5_complete;
    logic mm5_replay;

    // Nuke covers everything at or younger than nuke_robid
    assign nuke_hit = nuke_valid && store_unit_pkg::rob_older_or_equal(nuke_robid, req.robid);

    // An allocation that is nuked in the same cycle never lands
    assign alloc_ok = alloc &&
        !(nuke_valid && store_unit_pkg::rob_older_or_equal(nuke_robid, alloc_req.robid));

    assign mm5_hit      = valid && pipe_valid_mm5 && (pipe_pkt_mm5.stqid == id);
    assign mm5_complete = mm5_hit && (pipe_action_mm5 == store_unit_pkg::ACTION_COMPLETE);
    assign mm5_replay   = mm5_hit && (pipe_action_mm5 == store_unit_pkg::ACTION_REPLAY);

    // Only the oldest store in the machine may enter the pipe
    assign pipe_req     = valid && !in_pipe && (req.robid == oldest_robid);
    assign pipe_req_pkt = req;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid   <= 1'b0;
            in_pipe <= 1'b0;
        end else if (alloc_ok) begin
            valid   <= 1'b1;
            in_pipe <= 1'b0;
        end else if (nuke_hit || mm5_complete) begin
            valid   <= 1'b0;
            in_pipe <= 1'b0;
        end else if (mm5_replay) begin
            in_pipe <= 1'b0;
        end else if (pipe_gnt) begin
            in_pipe <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_ok) begin
            req <= alloc_req;
        end
    end

endmodule

/* logic/store_unit_pkg.sv */
`include "store_unit_settings.svh"

package store_unit_pkg;

    typedef logic [`ROB_ID_BITS-1:0] t_rob_id;
    typedef logic [$clog2(`STQ_NUM_ENTRIES)-1:0] t_stq_id;

    typedef enum logic [1:0] {
        OP_BYTE   = 2'd0,
        OP_HALF   = 2'd1,
        OP_WORD   = 2'd2,
        OP_DOUBLE = 2'd3
    } t_op_size;

    typedef struct packed {
        t_rob_id                robid;
        t_stq_id                stqid;
        logic [`ADDR_BITS-1:0]  addr;
        logic [`DATA_BITS-1:0]  data;
        t_op_size               size;
    } t_mempipe_req;

    typedef enum logic {
        ACTION_COMPLETE = 1'b0,
        ACTION_REPLAY   = 1'b1
    } t_mempipe_action;

    // True when robid a is at or before robid b in program order
    function automatic logic rob_older_or_equal(input t_rob_id a, input t_rob_id b);
        logic same_lap;
        logic older;
        same_lap = (a[`ROB_ID_BITS-1] == b[`ROB_ID_BITS-1]);
        // Different wrap bits mean a lives on the previous lap when its index is higher
        if (same_lap) begin
            older = (a[`ROB_ID_BITS-2:0] <= b[`ROB_ID_BITS-2:0]);
        end else begin
            older = (a[`ROB_ID_BITS-2:0] > b[`ROB_ID_BITS-2:0]);
        end
        return older;
    endfunction

endpackage

/* logic/store_unit_settings.svh */
`ifndef STORE_UNIT_SETTINGS_SVH
`define STORE_UNIT_SETTINGS_SVH

// Queue sizing
`define STQ_NUM_ENTRIES 8

// ROB id width with the wrap bit on top
`define ROB_ID_BITS 5

// Datapath widths
`define ADDR_BITS 32
`define DATA_BITS 64

// Memory pipe depth from mm1 to mm5
`define PIPE_STAGES 5

`endif

/* logic/store_unit_top.sv */
`timescale 1ns/10ps

`include "store_unit_settings.svh"

module store_unit_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    iss_valid,
    input  logic [6:0]              iss_opcode,
    input  logic [2:0]              iss_funct3,
    input  store_unit_pkg::t_rob_id iss_robid,
    input  store_unit_pkg::t_stq_id iss_stqid,
    input  logic [`ADDR_BITS-1:0]   iss_src1,
    input  logic [`ADDR_BITS-1:0]   iss_imm,
    input  logic [`DATA_BITS-1:0]   iss_src2,
    input  logic                    nuke_valid,
    input  store_unit_pkg::t_rob_id nuke_robid,
    input  store_unit_pkg::t_rob_id oldest_robid,
    input  logic                    port_blocked,
    output logic                    idle,
    output logic                    mem_wr_valid,
    output logic [`ADDR_BITS-1:0]   mem_wr_addr,
    output logic [`DATA_BITS-1:0]   mem_wr_data,
    output logic [`DATA_BITS/8-1:0] mem_wr_be
);

    logic                            alloc_valid;
    store_unit_pkg::t_stq_id         alloc_stqid;
    store_unit_pkg::t_mempipe_req    alloc_req;
    logic                            pipe_req;
    store_unit_pkg::t_mempipe_req    pipe_req_pkt;
    logic                            pipe_gnt;
    logic                            pipe_valid_mm5;
    store_unit_pkg::t_mempipe_req    pipe_pkt_mm5;
    store_unit_pkg::t_mempipe_action pipe_action_mm5;

    store_issue_decode i_decode (
        .iss_valid, .iss_opcode, .iss_funct3, .iss_robid, .iss_stqid,
        .iss_src1, .iss_imm, .iss_src2,
        .alloc_valid, .alloc_stqid, .alloc_req
    );

    store_queue i_queue (
        .clk, .reset, .alloc_valid, .alloc_stqid, .alloc_req, .oldest_robid,
        .nuke_valid, .nuke_robid, .pipe_gnt,
        .pipe_valid_mm5, .pipe_pkt_mm5, .pipe_action_mm5,
        .pipe_req, .pipe_req_pkt, .idle
    );

    store_mem_pipe i_pipe (
        .clk, .reset, .pipe_req, .pipe_req_pkt, .port_blocked, .nuke_valid, .nuke_robid,
        .pipe_gnt, .pipe_valid_mm5, .pipe_pkt_mm5, .pipe_action_mm5
    );

    store_write_format i_format (
        .clk, .reset, .pipe_valid_mm5, .pipe_pkt_mm5, .pipe_action_mm5,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data, .mem_wr_be
    );

endmodule

/* logic/store_write_format.sv */
`timescale 1ns/10ps

`include "store_unit_settings.svh"

module store_write_format (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            pipe_valid_mm5,
    input  store_unit_pkg::t_mempipe_req    pipe_pkt_mm5,
    input  store_unit_pkg::t_mempipe_action pipe_action_mm5,
    output logic                            mem_wr_valid,
    output logic [`ADDR_BITS-1:0]           mem_wr_addr,
    output logic [`DATA_BITS-1:0]           mem_wr_data,
    output logic [`DATA_BITS/8-1:0]         mem_wr_be
);

    logic                    wr_fire;
    logic [2:0]              lane;
    logic [`DATA_BITS/8-1:0] size_be;

    assign wr_fire = pipe_valid_mm5 && (pipe_action_mm5 == store_unit_pkg::ACTION_COMPLETE);
    assign lane    = pipe_pkt_mm5.addr[2:0];

    always_comb begin
        case (pipe_pkt_mm5.size)
            store_unit_pkg::OP_BYTE: size_be = 8'h01;
            store_unit_pkg::OP_HALF: size_be = 8'h03;
            store_unit_pkg::OP_WORD: size_be = 8'h0f;
            default:                 size_be = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wr_valid <= 1'b0;
        end else begin
            mem_wr_valid <= wr_fire;
        end
    end

    // Payload moves into its byte lanes of the 8-byte word
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem_wr_addr <= {pipe_pkt_mm5.addr[`ADDR_BITS-1:3], 3'b000};
            mem_wr_data <= pipe_pkt_mm5.data << {lane, 3'b000};
            mem_wr_be   <= size_be << lane;
        end
    end

endmodule
